// File: tb/prbs_tests.txt
# op cycles pause_percent expected_error_count
# The count is the error_count value expected at the end of the test
reset 3 0 0
run 40 0 0
pause 60 30 0
inject 20 0 1
inject 20 20 2
run 20 0 2
align 10 0 2
run 30 0 2
inject 20 0 3
reset 3 0 0
run 20 0 0

// File: prbs_loopback.f
+incdir+hw
hw/prbs_pkg.sv
hw/prbs_poly.sv
hw/prbs_generator.sv
hw/prbs_checker.sv
hw/prbs_loopback_top.sv
tb/prbs_monitor.sv
tb/prbs_loopback_tb.sv

// File: tb/prbs_loopback_tb.sv
`timescale 1ns/100ps
`include "prbs_defines.svh"

module prbs_loopback_tb;

  localparam int max_tests   = 64;
  localparam int op_reset    = 0;
  localparam int op_run      = 1;
  localparam int op_pause    = 2;
  localparam int op_align    = 3;
  localparam int op_inject   = 4;
  // Advancing edges after alignment before the checker can be locked
  localparam int lock_cycles = `PRBS_LOCK_COUNT + 2;

  logic                        clk;
  logic                        nreset;
  logic                        word_align;
  logic                        pause;
  logic                        insert_error;
  logic [`PRBS_DATA_WIDTH-1:0] dout;
  logic                        locked;
  logic [`PRBS_ERR_BITS-1:0]   error_count;

  // Reference model of the lane
  logic [`PRBS_DATA_WIDTH-1:0] model_word;
  logic                        model_pending;
  logic                        model_insert_q;
  int                          adv_count;
  logic                        exp_locked;

  int   test_op[max_tests];
  int   test_cycles[max_tests];
  int   test_density[max_tests];
  int   test_exp_errs[max_tests];
  int   num_tests;
  int   cycle_count;
  int   cycle_limit;
  int   lcg_state;
  logic file_bad;

  assign exp_locked = (adv_count >= lock_cycles);

  always #4 clk = ~clk;

  prbs_loopback_top i_prbs_loopback_top (
    .clk          (clk),
    .nreset       (nreset),
    .word_align   (word_align),
    .pause        (pause),
    .insert_error (insert_error),
    .dout         (dout),
    .locked       (locked),
    .error_count  (error_count)
  );

  prbs_monitor i_prbs_monitor (
    .clk         (clk),
    .dout        (dout),
    .locked      (locked),
    .error_count (error_count),
    .exp_dout    (model_word),
    .exp_locked  (exp_locked)
  );

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------

  function automatic int lcg_next(input int state);
    return state * 1103515245 + 12345;
  endfunction

  // Stream bits are laid out oldest first, and the history before the
  // current word repeats that word, so narrow lanes still see a full register
  function automatic logic [`PRBS_DATA_WIDTH-1:0] model_next_word(
      input logic [`PRBS_DATA_WIDTH-1:0] cur);
    logic [9*`PRBS_DATA_WIDTH-1:0] s;
    logic [`PRBS_DATA_WIDTH-1:0]   res;
    int                            tap;
    case (`PRBS_ORDER)
      7:       tap = 6;
      10:      tap = 7;
      23:      tap = 18;
      default: tap = 28;
    endcase
    for (int j = 0; j < 8*`PRBS_DATA_WIDTH; j++) begin
      s[j] = cur[`PRBS_DATA_WIDTH-1-(j % `PRBS_DATA_WIDTH)];
    end
    // Each new bit is the XOR of the bits order and tap places back
    for (int j = 8*`PRBS_DATA_WIDTH; j < 9*`PRBS_DATA_WIDTH; j++) begin
      s[j] = s[j-`PRBS_ORDER] ^ s[j-tap];
    end
    for (int i = 0; i < `PRBS_DATA_WIDTH; i++) begin
      res[i] = s[9*`PRBS_DATA_WIDTH-1-i];
    end
    return res;
  endfunction

  // A pulse edge arms one error, the next advancing edge spends it on bit 0
  always @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      model_word     <= `PRBS_DATA_WIDTH'(`PRBS_SEED);
      model_pending  <= 1'b0;
      model_insert_q <= 1'b0;
      adv_count      <= 0;
    end else begin
      model_insert_q <= insert_error;
      if (insert_error && !model_insert_q) begin
        model_pending <= 1'b1;
      end else if (word_align && !pause) begin
        model_pending <= 1'b0;
      end
      if (!word_align) begin
        model_word <= `PRBS_DATA_WIDTH'(`PRBS_ALIGN_WORD);
        adv_count  <= 0;
      end else if (!pause) begin
        model_word <= model_next_word(model_word) ^ `PRBS_DATA_WIDTH'(model_pending);
        if (adv_count < lock_cycles) begin
          adv_count <= adv_count + 1;
        end
      end
    end
  end

  // Timeout watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  function automatic string op_name(input int op);
    case (op)
      op_reset: return "reset";
      op_run:   return "run";
      op_pause: return "pause";
      op_align: return "align";
      default:  return "inject";
    endcase
  endfunction

  // Lines that do not hold four fields, such as comments, are skipped
  task automatic read_tests;
    int               fd;
    int               op;
    int               cyc;
    int               dens;
    int               errs;
    logic [63:0]      tok;
    logic [8*128-1:0] line;
    num_tests = 0;
    fd = $fopen("tb/prbs_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file tb/prbs_tests.txt");
      file_bad = 1'b1;
    end else begin
      while (!$feof(fd) && num_tests < max_tests) begin
        line = '0;
        op   = $fgets(line, fd);
        if ($sscanf(line, "%s %d %d %d", tok, cyc, dens, errs) == 4) begin
          case (tok)
            "reset":  op = op_reset;
            "run":    op = op_run;
            "pause":  op = op_pause;
            "align":  op = op_align;
            "inject": op = op_inject;
            default: begin
              $display("the test file holds an unknown operation");
              file_bad = 1'b1;
              op       = op_run;
            end
          endcase
          test_op[num_tests]       = op;
          test_cycles[num_tests]   = cyc;
          test_density[num_tests]  = dens;
          test_exp_errs[num_tests] = errs;
          num_tests++;
        end
      end
      $fclose(fd);
      if (num_tests == 0) begin
        $display("no tests were found in the test file");
        file_bad = 1'b1;
      end
    end
  endtask

  // Inputs change 1 ns after each rising edge
  task automatic run_test(input int idx);
    if (test_op[idx] == op_reset) begin
      nreset       = 1'b0;
      word_align   = 1'b1;
      pause        = 1'b0;
      insert_error = 1'b0;
      repeat (test_cycles[idx]) begin
        @(posedge clk);
        #1;
      end
      nreset = 1'b1;
    end else begin
      for (int c = 0; c < test_cycles[idx]; c++) begin
        lcg_state    = lcg_next(lcg_state);
        word_align   = (test_op[idx] != op_align);
        pause        = (((lcg_state >> 16) & 32'h7fff) % 100) < test_density[idx];
        insert_error = (test_op[idx] == op_inject) && (c == 0);
        @(posedge clk);
        #1;
      end
    end
    i_prbs_monitor.finish_test(op_name(test_op[idx]), test_exp_errs[idx]);
  endtask

  initial begin
    int total;
    clk          = 1'b0;
    nreset       = 1'b0;
    word_align   = 1'b1;
    pause        = 1'b0;
    insert_error = 1'b0;
    lcg_state    = 6913;
    cycle_count  = 0;
    file_bad     = 1'b0;
    total        = 0;
    read_tests();
    for (int i = 0; i < num_tests; i++) begin
      total += test_cycles[i];
    end
    cycle_limit = total + 100;
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    i_prbs_monitor.report_totals();
    if (!file_bad && i_prbs_monitor.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb/prbs_monitor.sv
`timescale 1ns/100ps
`include "prbs_defines.svh"

module prbs_monitor (
  input logic                        clk,
  input logic [`PRBS_DATA_WIDTH-1:0] dout,
  input logic                        locked,
  input logic [`PRBS_ERR_BITS-1:0]   error_count,
  input logic [`PRBS_DATA_WIDTH-1:0] exp_dout,
  input logic                        exp_locked
);

  int test_count = 0;
  int pass_count = 0;
  int fail_count = 0;
  // Mismatches seen since the current test started
  int test_errs  = 0;

  // Lane word and lock are compared in the middle of every cycle, well
  // away from the clock edge and the input changes
  always @(negedge clk) begin
    if (dout !== exp_dout) begin
      $display("error dout: got %h expected %h", dout, exp_dout);
      test_errs++;
    end
    if (exp_locked && !locked) begin
      $display("lock missing: locked is still low after enough good words");
      test_errs++;
    end else if (locked !== exp_locked) begin
      $display("error locked: got %h expected %h", locked, exp_locked);
      test_errs++;
    end
  end

  // Called by the bench just after the last edge of a test
  task automatic finish_test(input string name, input int exp_errs);
    logic [`PRBS_ERR_BITS-1:0] want;
    want = `PRBS_ERR_BITS'(exp_errs);
    if (error_count !== want) begin
      $display("error error_count: got %h expected %h", error_count, want);
      test_errs++;
    end
    test_count++;
    if (test_errs == 0) begin
      pass_count++;
      $display("test %0d %s: passed", test_count, name);
    end else begin
      fail_count++;
      $display("test %0d %s: failed with %0d mismatches", test_count, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic report_totals;
    $display("tests run %0d, passed %0d, failed %0d", test_count, pass_count, fail_count);
  endtask

endmodule

// File: hw/prbs_loopback_top.sv
`timescale 1ns/100ps
`include "prbs_defines.svh"

module prbs_loopback_top (
  input  logic                        clk,
  input  logic                        nreset,
  // Low while word alignment is pending
  input  logic                        word_align,
  // High stalls the lane, the generator then holds its word
  input  logic                        pause,
  // Each rising edge corrupts one transmitted word
  input  logic                        insert_error,
  output logic [`PRBS_DATA_WIDTH-1:0] dout,
  output logic                        locked,
  output logic [`PRBS_ERR_BITS-1:0]   error_count
);

  // Generator side of the lane
  // Its output goes out of the top level and straight into the checker,
  // standing in for a transceiver loopback
  prbs_generator i_prbs_generator (
    .clk          (clk),
    .nreset       (nreset),
    .word_align   (word_align),
    .pause        (pause),
    .insert_error (insert_error),
    .dout         (dout)
  );

  // Checker side of the lane
  // It sees the same alignment and pause levels as the generator, there
  // is no handshake between the two
  prbs_checker i_prbs_checker (
    .clk         (clk),
    .nreset      (nreset),
    .din         (dout),
    .word_align  (word_align),
    .pause       (pause),
    .locked      (locked),
    .error_count (error_count)
  );

endmodule

// File: hw/prbs_checker.sv
`timescale 1ns/100ps
`include "prbs_defines.svh"

module prbs_checker (
  input  logic                      clk,
  input  logic                      nreset,
  input  prbs_pkg::prbs_word_t      din,
  input  logic                      word_align,
  input  logic                      pause,
  output logic                      locked,
  output logic [`PRBS_ERR_BITS-1:0] error_count
);
  import prbs_pkg::*;

  localparam int unsigned run_w = $clog2(`PRBS_LOCK_COUNT + 1);
  localparam logic [run_w-1:0] lock_run = run_w'(`PRBS_LOCK_COUNT);

  // Same advance condition as the generator, seen from the lane controls
  logic             advance;
  // Stage 1 holds the word that was on the lane just before an advancing edge
  prbs_word_t       s1_word;
  logic             s1_valid;
  // Stage 2 holds the prediction made from the last compared word
  prbs_word_t       pred_word;
  logic             seeded;
  logic             word_match;
  // Consecutive good words since alignment or since the last mismatch
  logic [run_w-1:0] run_count;

  assign advance    = word_align & ~pause;
  assign word_match = (s1_word == pred_word);

  // ----------------------------------------------------------------------
  // Capture stage
  // ----------------------------------------------------------------------

  // Sampling only at advancing edges picks up every lane word exactly once,
  // since the generator holds its word through paused cycles
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      s1_valid <= 1'b0;
    end else if (!word_align) begin
      s1_valid <= 1'b0;
    end else if (!pause) begin
      s1_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_word <= din;
    end
  end

  // ----------------------------------------------------------------------
  // Compare stage
  // ----------------------------------------------------------------------

  // The checker is self-synchronizing because the prediction is always
  // rebuilt from the received word, so one corrupted word gives one
  // mismatch and the next word matches again
  always_ff @(posedge clk) begin
    if (advance && s1_valid) begin
      pred_word <= prbs_next(s1_word, `PRBS_ORDER);
    end
  end

  // The first word after alignment or reset only seeds the prediction
  // Lock survives mismatches and drops only on reset or realignment
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      seeded      <= 1'b0;
      run_count   <= '0;
      locked      <= 1'b0;
      error_count <= '0;
    end else if (!word_align) begin
      seeded    <= 1'b0;
      run_count <= '0;
      locked    <= 1'b0;
    end else if (advance && s1_valid) begin
      seeded <= 1'b1;
      if (seeded) begin
        if (word_match) begin
          if (run_count != lock_run) begin
            run_count <= run_count + 1'b1;
          end
          if (run_count == lock_run - 1'b1) begin
            locked <= 1'b1;
          end
        end else begin
          run_count <= '0;
          // Counter sticks at all ones rather than wrapping
          if (locked && (error_count != '1)) begin
            error_count <= error_count + 1'b1;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Saturation and the realignment path must never lose counted errors
  a_count_monotonic : assert property (
    @(posedge clk) disable iff (!nreset)
    error_count >= $past(error_count)
  );

  // Lock stays low through alignment and through the capture and seeding
  // edges that follow it, since no word has been compared yet
  a_no_lock_in_align : assert property (
    @(posedge clk) disable iff (!nreset)
    ($past(!word_align) || $past(!word_align, 2) || $past(!word_align, 3))
      |-> !locked
  );

endmodule

// File: hw/prbs_generator.sv
`timescale 1ns/100ps
`include "prbs_defines.svh"

module prbs_generator (
  input  logic                 clk,
  input  logic                 nreset,
  input  logic                 word_align,
  input  logic                 pause,
  input  logic                 insert_error,
  output prbs_pkg::prbs_word_t dout
);
  import prbs_pkg::*;

  // Candidate word for the next advancing edge, error already applied
  prbs_word_t next_word;
  // The lane moves on only when alignment is done and pause is low
  logic       advance;

  assign advance = word_align & ~pause;

  // Transmit register
  // Alignment wins over pause, so the alignment word appears even while
  // the lane is stalled
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      dout <= prbs_word_t'(`PRBS_SEED);
    end else if (!word_align) begin
      dout <= prbs_word_t'(`PRBS_ALIGN_WORD);
    end else if (!pause) begin
      dout <= next_word;
    end
  end

  prbs_poly i_prbs_poly (
    .clk          (clk),
    .nreset       (nreset),
    .data_in      (dout),
    .insert_error (insert_error),
    .advance      (advance),
    .dout         (next_word)
  );

  // An all-zero word would lock the register up for good
  a_dout_nonzero : assert property (
    @(posedge clk) disable iff (!nreset)
    dout != '0
  );

endmodule

// File: hw/prbs_poly.sv
`timescale 1ns/100ps
`include "prbs_defines.svh"

module prbs_poly (
  input  logic                 clk,
  input  logic                 nreset,
  input  prbs_pkg::prbs_word_t data_in,
  input  logic                 insert_error,
  input  logic                 advance,
  output prbs_pkg::prbs_word_t dout
);
  import prbs_pkg::*;

  // Previous level of insert_error, for edge detection
  logic       insert_error_q;
  // Set by a rising edge, held until an advancing edge loads the bad word
  logic       err_pending;
  logic       err_rise;
  // Only bit 0 is ever flipped
  prbs_word_t err_mask;

  assign err_rise = insert_error & ~insert_error_q;
  assign err_mask = prbs_word_t'(err_pending);

  // Next word always comes from the word actually on the lane, so after
  // a corrupted word the stream carries on from the corrupted value
  assign dout = prbs_next(data_in, `PRBS_ORDER) ^ err_mask;

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      insert_error_q <= 1'b0;
    end else begin
      insert_error_q <= insert_error;
    end
  end

  // A pulse that arrives during pause or alignment stays pending, so
  // every pulse costs exactly one word once the lane moves again
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      err_pending <= 1'b0;
    end else if (err_rise) begin
      err_pending <= 1'b1;
    end else if (advance) begin
      err_pending <= 1'b0;
    end
  end

  // The tap table in the package covers only these orders
  a_order_supported : assert property (
    @(posedge clk) disable iff (!nreset)
    `PRBS_ORDER inside {7, 10, 23, 31}
  );

endmodule

// File: hw/prbs_pkg.sv
`include "prbs_defines.svh"

package prbs_pkg;

  // One lane word, bit PRBS_DATA_WIDTH-1 is the oldest bit of the stream
  // and bit 0 the newest
  typedef logic [`PRBS_DATA_WIDTH-1:0] prbs_word_t;

  // ----------------------------------------------------------------------
  // Polynomial taps
  // ----------------------------------------------------------------------

  // Second tap of each supported polynomial x^order + x^tap + 1
  // Order 31 falls into the default arm
  function automatic int unsigned prbs_tap(input int unsigned order);
    case (order)
      7:       return 6;
      10:      return 7;
      23:      return 18;
      default: return 28;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Next-word step
  // ----------------------------------------------------------------------

  // Advances a Fibonacci register once per lane bit, oldest bit first
  // Bit k of the history holds the stream bit k+1 places back, so the
  // feedback bit is hist[order-1] ^ hist[tap-1] and it enters at bit 0
  // The current word is replicated upward to fill the history, which only
  // matters for lanes narrower than the pattern order
  function automatic prbs_word_t prbs_next(input prbs_word_t cur,
                                           input int unsigned order);
    logic [8*`PRBS_DATA_WIDTH-1:0] rep;
    logic [63:0]                   hist;
    logic                          fb;
    int unsigned                   tap;

    rep  = {8{cur}};
    hist = rep[63:0];
    tap  = prbs_tap(order);
    for (int i = 0; i < `PRBS_DATA_WIDTH; i++) begin
      fb   = hist[order-1] ^ hist[tap-1];
      hist = {hist[62:0], fb};
    end
    // After one full word of shifts the low bits are all new stream bits
    return hist[`PRBS_DATA_WIDTH-1:0];
  endfunction

endpackage

// File: hw/prbs_defines.svh
`ifndef PRBS_DEFINES_SVH
`define PRBS_DEFINES_SVH

// Lane width in bits per clock
// Legal values are 8, 10, 16, 20, 32, 40 and 64
`define PRBS_DATA_WIDTH 32

// Pattern order, one of 7, 10, 23 or 31
// The lane carries the true maximal-length sequence only when the
// lane width is at least the pattern order
`define PRBS_ORDER 31

// Word loaded into the generator at reset, must be nonzero
`define PRBS_SEED 97

// Word sent on the lane while word alignment is still pending
`define PRBS_ALIGN_WORD 97

// Consecutive good words the checker needs before it declares lock
`define PRBS_LOCK_COUNT 8

// Width of the saturating errored-word counter
`define PRBS_ERR_BITS 16

`endif
